/* dv/u2_ctrl_chk.sv */
/*
 Ack rules of the control core bus, bound into u2_ctrl_core.
*/
`default_nettype none
`include "u2_ctrl_params.svh"

module u2_ctrl_chk (
   input logic                  dsp_clk,
   input logic                  wb_rst,
   input logic                  stb_i,
   input u2_ctrl_pkg::wb_addr_t adr_i,
   input logic                  ack_o
);

   logic [`U2_DECODE_W-1:0] win_sel;
   logic                    win_hit;
   int unsigned             assert_fails = 0;

   assign win_sel = adr_i[`U2_AW-1 -: `U2_DECODE_W];
   assign win_hit = (win_sel == `U2_WIN_SETTINGS) || (win_sel == `U2_WIN_READBACK);

   // Without a new strobe the ack drops after one cycle
   ack_single: assert property (@(posedge dsp_clk) disable iff (wb_rst)
                                (ack_o && !stb_i) |=> !ack_o)
      else begin
         $error("ack held for a second cycle without a new strobe");
         assert_fails++;
      end

   ack_follows: assert property (@(posedge dsp_clk) disable iff (wb_rst)
                                 (stb_i && win_hit) |=> ack_o)
      else begin
         $error("window hit strobe not acknowledged in the next cycle");
         assert_fails++;
      end

   ack_reset: assert property (@(posedge dsp_clk) wb_rst |=> !ack_o)
      else begin
         $error("ack high in the cycle after reset");
         assert_fails++;
      end

endmodule

bind u2_ctrl_core u2_ctrl_chk u_u2_ctrl_chk (
   .dsp_clk (dsp_clk),
   .wb_rst  (wb_rst),
   .stb_i   (stb_i),
   .adr_i   (adr_i),
   .ack_o   (ack_o)
);

`default_nettype wire

/* dv/u2_ctrl_tb.sv */
/*
 Directed tests of the control core. Inputs change on the falling edge and
 outputs are sampled on a later falling edge. Random data comes from a 16-bit LFSR.
*/
`default_nettype none
`include "u2_ctrl_params.svh"

module u2_ctrl_tb;

   import u2_ctrl_pkg::*;

   localparam int CLK_PERIOD    = 8;
   localparam int N_TESTS       = 6;
   localparam int WATCHDOG_TIME = (N_TESTS * 200 + 3) * CLK_PERIOD;

   logic        dsp_clk;
   logic        wb_rst;
   logic        stb_i;
   logic        we_i;
   wb_addr_t    adr_i;
   wb_data_t    dat_i;
   wb_data_t    dat_o;
   logic        ack_o;
   irq_src_t    irq_src_i;
   logic        sim_mode_i;
   logic [3:0]  clock_divider_i;
   ctrl_lines_t ctrl_o;
   logic        phy_resetn_o;
   page_t       page_o;
   led_t        leds_o;

   // Expected setting state
   logic [4:0]  exp_clock;
   logic [3:0]  exp_serdes;
   logic [3:0]  exp_adc;
   logic        exp_phy;
   page_t       exp_page;

   logic [15:0] lfsr_q;
   int          error_count;
   int          tests_run;

   u2_ctrl_core u_u2_ctrl_core (.*);

   initial begin
      dsp_clk = 1'b0;
      forever #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;
   end

   // 200 cycles for each test
   initial begin
      #(WATCHDOG_TIME);
      $display("Watchdog expired before the tests completed");
      $display("TESTS FAILED");
      $finish;
   end

   ////////////////////
   // Helpers
   ////////////////////

   // Taps 16, 14, 13, 11
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] bits;
      logic        fb;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
         lfsr_q = {lfsr_q[14:0], fb};
         bits   = {bits[30:0], fb};
      end
      return bits;
   endfunction

   task automatic value_error(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      $display("ERROR %s got %h expected %h", name, got, expected);
      error_count++;
   endtask

   task automatic finish_test(input string name, input int errs_before);
      $display("%-14s done, %0d errors", name, error_count - errs_before);
      tests_run++;
   endtask

   // One strobe with the ack expected in the next cycle
   task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t wdata,
                             output wb_data_t rdata);
      @(negedge dsp_clk);
      stb_i = 1'b1;
      we_i  = we;
      adr_i = adr;
      dat_i = wdata;
      @(negedge dsp_clk);
      rdata = dat_o;
      stb_i = 1'b0;
      if (ack_o !== 1'b1) value_error("ack_o", 32'(ack_o), 32'h1);
   endtask

   task automatic bus_write(input logic [7:0] sr, input wb_data_t data);
      wb_data_t rd_ignored;
      bus_access(1'b1, {`U2_WIN_SETTINGS, sr, 2'b00}, data, rd_ignored);
   endtask

   task automatic bus_read(input rb_word_t word, output wb_data_t data);
      bus_access(1'b0, {`U2_WIN_READBACK, 4'b0000, word, 2'b00}, '0, data);
   endtask

   task automatic check_pins();
      logic [12:0] ctrl_exp;
      logic        phy_exp;
      ctrl_exp = {exp_clock, exp_serdes, exp_adc};
      phy_exp  = ~exp_phy;
      if (ctrl_o !== ctrl_exp) value_error("ctrl_o", 32'(ctrl_o), 32'(ctrl_exp));
      if (phy_resetn_o !== phy_exp) value_error("phy_resetn_o", 32'(phy_resetn_o), 32'(phy_exp));
      if (page_o !== exp_page) value_error("page_o", 32'(page_o), 32'(exp_page));
   endtask

   // Old value in the ack cycle, new value one cycle later
   task automatic write_and_check(input logic [7:0] sr, input wb_data_t d);
      bus_write(sr, d);
      check_pins();
      case (sr)
         `U2_SR_CLOCK:  exp_clock  = d[4:0];
         `U2_SR_SERDES: exp_serdes = d[3:0];
         `U2_SR_ADC:    exp_adc    = d[3:0];
         `U2_SR_PHY:    exp_phy    = d[0];
         `U2_SR_PAGE:   exp_page   = d[`U2_PAGE_W-1:0];
         default:       ;
      endcase
      @(negedge dsp_clk);
      check_pins();
   endtask

   ////////////////////
   // Tests
   ////////////////////

   task automatic test_after_reset();
      int errs;
      errs = error_count;
      if (leds_o !== 8'h00) value_error("leds_o", 32'(leds_o), 32'h0);
      check_pins();
      finish_test("after_reset", errs);
   endtask

   task automatic test_control_pins();
      int errs;
      errs = error_count;
      for (int i = 0; i < 3; i++) begin
         write_and_check(`U2_SR_CLOCK, take_bits(32));
         write_and_check(`U2_SR_SERDES, take_bits(32));
         write_and_check(`U2_SR_ADC, take_bits(32));
         write_and_check(`U2_SR_PHY, take_bits(32));
         write_and_check(`U2_SR_PAGE, take_bits(32));
         write_and_check(8'd5, take_bits(32));
      end
      finish_test("control_pins", errs);
   endtask

   task automatic test_led_mix();
      int   errs;
      led_t sw;
      led_t src;
      led_t hw;
      led_t led_exp;
      errs = error_count;
      for (int i = 0; i < 6; i++) begin
         sw  = led_t'(take_bits(8));
         src = led_t'(take_bits(8));
         bus_write(`U2_SR_LED_SW, 32'(sw));
         bus_write(`U2_SR_LED_SRC, 32'(src));
         irq_src_i.clk_status     = 1'(take_bits(1));
         irq_src_i.serdes_link_up = 1'(take_bits(1));
         @(negedge dsp_clk);
         hw = {6'b0, irq_src_i.clk_status, irq_src_i.serdes_link_up};
         for (int b = 0; b < 8; b++) begin
            led_exp[b] = src[b] ? hw[b] : sw[b];
         end
         if (leds_o !== led_exp) value_error("leds_o", 32'(leds_o), 32'(led_exp));
      end
      finish_test("led_mix", errs);
   endtask

   task automatic test_mode_irq();
      int       errs;
      wb_data_t rd;
      wb_data_t vec;
      wb_data_t enc;
      errs = error_count;
      for (int i = 0; i < 3; i++) begin
         sim_mode_i      = 1'(take_bits(1));
         clock_divider_i = 4'(take_bits(4));
         bus_read(`U2_RB_MODE, rd);
         vec      = '0;
         vec[31]  = sim_mode_i;
         vec[3:0] = clock_divider_i;
         if (rd !== vec) value_error("dat_o word 9", rd, vec);
      end
      for (int i = 0; i < 8; i++) begin
         // First pass with no interrupt set
         irq_src_i = (i == 0) ? '0 : irq_src_t'(take_bits(12));
         vec       = '0;
         vec[7:0]  = {irq_src_i.pps, irq_src_i.overrun, irq_src_i.underrun,
                      irq_src_i.phy_int_n, irq_src_i.i2c, irq_src_i.spi,
                      irq_src_i.timer, irq_src_i.buffer};
         vec[11:8] = {irq_src_i.clk_status, irq_src_i.serdes_link_up,
                      irq_src_i.uart_tx, irq_src_i.uart_rx};
         enc = `U2_IRQ_NONE;
         for (int b = 15; b >= 0; b--) begin
            if (vec[b] && enc == `U2_IRQ_NONE) enc = 32'(b);
         end
         bus_read(`U2_RB_IRQ, rd);
         if (rd !== vec) value_error("dat_o word 13", rd, vec);
         bus_read(`U2_RB_IRQ_ENC, rd);
         if (rd !== enc) value_error("dat_o word 14", rd, enc);
      end
      for (int w = 0; w <= 8; w++) begin
         bus_read(rb_word_t'(w), rd);
         if (rd !== '0) value_error($sformatf("dat_o word %0d", w), rd, 32'h0);
      end
      finish_test("mode_irq", errs);
   endtask

   task automatic test_cycle_counter();
      int       errs;
      wb_data_t first;
      wb_data_t second;
      errs = error_count;
      for (int k = 2; k < 40; k += 9) begin
         bus_read(`U2_RB_CYCLES, first);
         repeat (k - 2) @(negedge dsp_clk);
         bus_read(`U2_RB_CYCLES, second);
         if (second - first !== 32'(k)) value_error("cycle delta", second - first, 32'(k));
      end
      finish_test("cycle_counter", errs);
   endtask

   task automatic test_unmapped();
      int       errs;
      logic     acked;
      wb_data_t rd;
      errs  = error_count;
      acked = 1'b0;
      @(negedge dsp_clk);
      stb_i = 1'b1;
      we_i  = 1'(take_bits(1));
      adr_i = {6'b011010, 10'(take_bits(10))};
      dat_i = take_bits(32);
      @(negedge dsp_clk);
      stb_i = 1'b0;
      repeat (4) begin
         acked = acked | ack_o;
         @(negedge dsp_clk);
      end
      if (acked) begin
         $display("Unmapped access to address %h was acknowledged", adr_i);
         error_count++;
      end
      sim_mode_i      = 1'b1;
      clock_divider_i = 4'ha;
      bus_read(`U2_RB_MODE, rd);
      if (rd !== 32'h8000_000a) value_error("dat_o word 9", rd, 32'h8000_000a);
      finish_test("unmapped", errs);
   endtask

   ////////////////////
   // Sequence
   ////////////////////

   initial begin
      lfsr_q          = 16'd41;
      error_count     = 0;
      tests_run       = 0;
      wb_rst          = 1'b1;
      stb_i           = 1'b0;
      we_i            = 1'b0;
      adr_i           = '0;
      dat_i           = '0;
      irq_src_i       = '0;
      sim_mode_i      = 1'b0;
      clock_divider_i = 4'h0;
      exp_clock       = '0;
      exp_serdes      = '0;
      exp_adc         = '0;
      exp_phy         = 1'b0;
      exp_page        = '0;
      repeat (3) @(posedge dsp_clk);
      @(negedge dsp_clk);
      wb_rst = 1'b0;

      test_after_reset();
      test_control_pins();
      test_led_mix();
      test_mode_irq();
      test_cycle_counter();
      test_unmapped();

      error_count += u_u2_ctrl_core.u_u2_ctrl_chk.assert_fails;
      $display("%0d tests run, %0d errors", tests_run, error_count);
      if (error_count == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* hdl/bus_addr_decode.sv */
/*
 Single master, one-cycle strobes, no back-pressure. A hit acks one cycle later;
 a miss on both windows never acks.
*/
`default_nettype none
`include "u2_ctrl_params.svh"

module bus_addr_decode (
   input  logic                     dsp_clk,
   input  logic                     wb_rst,
   input  logic                     stb_i,
   input  logic                     we_i,
   input  u2_ctrl_pkg::wb_addr_t    adr_i,
   input  u2_ctrl_pkg::wb_data_t    dat_i,
   output u2_ctrl_pkg::setting_wr_t set_wr_o,
   output u2_ctrl_pkg::rb_req_t     rb_req_o,
   output logic                     ack_o
);

   logic [`U2_DECODE_W-1:0] win_sel;
   logic                    hit_set;
   logic                    hit_rb;

   ////////////////////
   // Window decode
   ////////////////////

   assign win_sel = adr_i[`U2_AW-1 -: `U2_DECODE_W];
   assign hit_set = (win_sel == `U2_WIN_SETTINGS);
   assign hit_rb  = (win_sel == `U2_WIN_READBACK);

   ////////////////////
   // Registered request
   ////////////////////

   // Ack and request strobes
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         ack_o           <= 1'b0;
         set_wr_o.strobe <= 1'b0;
         rb_req_o.valid  <= 1'b0;
      end else begin
         // Read of the settings window still acks, with zero data
         ack_o           <= stb_i & (hit_set | hit_rb);
         set_wr_o.strobe <= stb_i & we_i & hit_set;
         rb_req_o.valid  <= stb_i & ~we_i & hit_rb;
      end
   end

   // Payload follows the bus every cycle
   always_ff @(posedge dsp_clk) begin
      set_wr_o.addr <= adr_i[9:2];
      set_wr_o.data <= dat_i;
      rb_req_o.word <= adr_i[5:2];
   end

endmodule

`default_nettype wire

/* hdl/setting_regs.sv */
/*
 Setting bank at addresses 0,1,2,3,4,6,8; other addresses are ignored.
 A write strobed in cycle N+1 shows on the pins from cycle N+2.
*/
`default_nettype none
`include "u2_ctrl_params.svh"

module setting_regs (
   input  logic                     dsp_clk,
   input  logic                     wb_rst,
   input  u2_ctrl_pkg::setting_wr_t set_wr_i,
   input  logic                     clk_status_i,
   input  logic                     serdes_link_up_i,
   output u2_ctrl_pkg::ctrl_lines_t ctrl_o,
   output logic                     phy_resetn_o,
   output u2_ctrl_pkg::page_t       page_o,
   output u2_ctrl_pkg::led_t        leds_o
);

   import u2_ctrl_pkg::*;

   logic [4:0] clock_q;
   logic [3:0] serdes_q;
   logic [3:0] adc_q;
   logic       phy_q;
   page_t      page_q;
   led_t       led_sw_q;
   led_t       led_src_q;
   led_t       led_hw;

   ////////////////////
   // Register bank
   ////////////////////

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         clock_q   <= '0;
         serdes_q  <= '0;
         adc_q     <= '0;
         phy_q     <= 1'b0;
         page_q    <= '0;
         led_sw_q  <= '0;
         led_src_q <= '0;
      end else if (set_wr_i.strobe) begin
         case (set_wr_i.addr)
            `U2_SR_CLOCK: begin
               clock_q <= set_wr_i.data[4:0];
            end
            `U2_SR_SERDES: begin
               serdes_q <= set_wr_i.data[3:0];
            end
            `U2_SR_ADC: begin
               adc_q <= set_wr_i.data[3:0];
            end
            `U2_SR_LED_SW: begin
               led_sw_q <= set_wr_i.data[7:0];
            end
            `U2_SR_PHY: begin
               phy_q <= set_wr_i.data[0];
            end
            `U2_SR_PAGE: begin
               page_q <= set_wr_i.data[`U2_PAGE_W-1:0];
            end
            `U2_SR_LED_SRC: begin
               led_src_q <= set_wr_i.data[7:0];
            end
            default: begin
               // Unmapped setting addresses are ignored
            end
         endcase
      end
   end

   ////////////////////
   // Control pins
   ////////////////////

   // Clock word on top, then SERDES, then ADC
   assign ctrl_o       = ctrl_lines_t'({clock_q, serdes_q, adc_q});
   assign phy_resetn_o = ~phy_q;
   assign page_o       = page_q;

   ////////////////////
   // LED mix
   ////////////////////

   // Source bit 1 selects hardware, 0 selects software
   assign led_hw = {6'b0, clk_status_i, serdes_link_up_i};
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

endmodule

`default_nettype wire

/* hdl/status_readback.sv */
/*
 16-word status window. dat_o is combinational from the registered request
 and reads zero outside a read ack.
*/
`default_nettype none
`include "u2_ctrl_params.svh"

module status_readback (
   input  logic                  dsp_clk,
   input  logic                  wb_rst,
   input  u2_ctrl_pkg::rb_req_t  rb_req_i,
   input  u2_ctrl_pkg::irq_src_t irq_src_i,
   input  logic                  sim_mode_i,
   input  logic [3:0]            clock_divider_i,
   output u2_ctrl_pkg::wb_data_t dat_o
);

   import u2_ctrl_pkg::*;

   wb_data_t cycle_q;
   wb_data_t irq_vec;
   wb_data_t irq_enc;

   ////////////////////
   // Cycle counter
   ////////////////////

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         cycle_q <= '0;
      end else begin
         cycle_q <= cycle_q + 1'b1;
      end
   end

   ////////////////////
   // Interrupt vector
   ////////////////////

   assign irq_vec = {20'b0,
                     irq_src_i.clk_status,
                     irq_src_i.serdes_link_up,
                     irq_src_i.uart_tx,
                     irq_src_i.uart_rx,
                     irq_src_i.pps,
                     irq_src_i.overrun,
                     irq_src_i.underrun,
                     irq_src_i.phy_int_n,
                     irq_src_i.i2c,
                     irq_src_i.spi,
                     irq_src_i.timer,
                     irq_src_i.buffer};

   // Highest set bit of the low half wins
   always_comb begin
      irq_enc = `U2_IRQ_NONE;
      for (int i = 0; i < 16; i++) begin
         if (irq_vec[i]) begin
            irq_enc = wb_data_t'(i);
         end
      end
   end

   ////////////////////
   // Word mux
   ////////////////////

   always_comb begin
      dat_o = '0;
      if (rb_req_i.valid) begin
         case (rb_req_i.word)
            `U2_RB_MODE:    dat_o = {sim_mode_i, 27'b0, clock_divider_i};
            `U2_RB_IRQ:     dat_o = irq_vec;
            `U2_RB_IRQ_ENC: dat_o = irq_enc;
            `U2_RB_CYCLES:  dat_o = cycle_q;
            default:        dat_o = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* hdl/u2_ctrl_core.sv */
/*
 Control-plane core, all on dsp_clk. Link-up and clock status for the LEDs
 are taken from the interrupt source bundle.
*/
`default_nettype none

module u2_ctrl_core (
   input  logic                     dsp_clk,
   input  logic                     wb_rst,

   // Bus slave port
   input  logic                     stb_i,
   input  logic                     we_i,
   input  u2_ctrl_pkg::wb_addr_t    adr_i,
   input  u2_ctrl_pkg::wb_data_t    dat_i,
   output u2_ctrl_pkg::wb_data_t    dat_o,
   output logic                     ack_o,

   // Status inputs
   input  u2_ctrl_pkg::irq_src_t    irq_src_i,
   input  logic                     sim_mode_i,
   input  logic [3:0]               clock_divider_i,

   // Control pins
   output u2_ctrl_pkg::ctrl_lines_t ctrl_o,
   output logic                     phy_resetn_o,
   output u2_ctrl_pkg::page_t       page_o,
   output u2_ctrl_pkg::led_t        leds_o
);

   import u2_ctrl_pkg::*;

   setting_wr_t set_wr;
   rb_req_t     rb_req;

   ////////////////////
   // Address decode
   ////////////////////

   bus_addr_decode u_bus_addr_decode (
      .dsp_clk  (dsp_clk),
      .wb_rst   (wb_rst),
      .stb_i    (stb_i),
      .we_i     (we_i),
      .adr_i    (adr_i),
      .dat_i    (dat_i),
      .set_wr_o (set_wr),
      .rb_req_o (rb_req),
      .ack_o    (ack_o)
   );

   ////////////////////
   // Settings
   ////////////////////

   setting_regs u_setting_regs (
      .dsp_clk          (dsp_clk),
      .wb_rst           (wb_rst),
      .set_wr_i         (set_wr),
      .clk_status_i     (irq_src_i.clk_status),
      .serdes_link_up_i (irq_src_i.serdes_link_up),
      .ctrl_o           (ctrl_o),
      .phy_resetn_o     (phy_resetn_o),
      .page_o           (page_o),
      .leds_o           (leds_o)
   );

   ////////////////////
   // Status readback
   ////////////////////

   status_readback u_status_readback (
      .dsp_clk         (dsp_clk),
      .wb_rst          (wb_rst),
      .rb_req_i        (rb_req),
      .irq_src_i       (irq_src_i),
      .sim_mode_i      (sim_mode_i),
      .clock_divider_i (clock_divider_i),
      .dat_o           (dat_o)
   );

endmodule

`default_nettype wire

/* hdl/u2_ctrl_params.svh */
/*
 Widths, window decode values and address maps of the control core.
 Setting and readback numbers must match the decode bits taken in bus_addr_decode.
*/
`ifndef U2_CTRL_PARAMS_SVH
`define U2_CTRL_PARAMS_SVH

// Bus widths
`define U2_DW           32
`define U2_AW           16
`define U2_DECODE_W     6

// Window decode values on the upper address bits
`define U2_WIN_SETTINGS 6'b110101
`define U2_WIN_READBACK 6'b110011

// Setting register addresses
`define U2_SR_CLOCK     8'd0
`define U2_SR_SERDES    8'd1
`define U2_SR_ADC       8'd2
`define U2_SR_LED_SW    8'd3
`define U2_SR_PHY       8'd4
`define U2_SR_PAGE      8'd6
`define U2_SR_LED_SRC   8'd8

// Readback word numbers
`define U2_RB_MODE      4'd9
`define U2_RB_IRQ       4'd13
`define U2_RB_IRQ_ENC   4'd14
`define U2_RB_CYCLES    4'd15

`define U2_PAGE_W       20
`define U2_IRQ_NONE     32'd32

`endif

/* hdl/u2_ctrl_pkg.sv */
/*
 Types shared by the control core. Widths come from the params header.
*/
`default_nettype none
`include "u2_ctrl_params.svh"

package u2_ctrl_pkg;

   typedef logic [`U2_DW-1:0]     wb_data_t;
   typedef logic [`U2_AW-1:0]     wb_addr_t;
   typedef logic [7:0]            set_addr_t;
   typedef logic [3:0]            rb_word_t;
   typedef logic [7:0]            led_t;
   typedef logic [`U2_PAGE_W-1:0] page_t;

   // One settings bus write
   typedef struct packed {
      logic      strobe;
      set_addr_t addr;
      wb_data_t  data;
   } setting_wr_t;

   typedef struct packed {
      logic     valid;
      rb_word_t word;
   } rb_req_t;

   // Interrupt and status lines, in the order of the original top level
   typedef struct packed {
      logic pps;
      logic overrun;
      logic underrun;
      logic phy_int_n;
      logic i2c;
      logic spi;
      logic timer;
      logic buffer;
      logic uart_tx;
      logic uart_rx;
      logic serdes_link_up;
      logic clk_status;
   } irq_src_t;

   // Packing order matches the low bits of the clock, SERDES and ADC settings
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
   } ctrl_lines_t;

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the control core testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module u2_ctrl_tb -f tb.f &&
{ sim_out=$(./obj_dir/Vu2_ctrl_tb +verilator+error+limit+100); echo "$sim_out"; } &&
echo "$sim_out" | grep -qx "TESTS PASSED" ||
{ echo "Simulation did not pass"; exit 1; }

/* tb.f */
+incdir+hdl
hdl/u2_ctrl_pkg.sv
hdl/bus_addr_decode.sv
hdl/setting_regs.sv
hdl/status_readback.sv
hdl/u2_ctrl_core.sv
dv/u2_ctrl_chk.sv
dv/u2_ctrl_tb.sv
